//--- rtl/snake_pkg.sv
package snake_pkg;

    localparam int COORD_BITS = 7;
    localparam int SCORE_BITS = 7;

    // One grid coordinate, all ones marks an empty body segment
    typedef logic [COORD_BITS-1:0] coord_t;

    localparam coord_t UNUSED_COORD = '1;

    typedef enum logic [1:0] {
        up    = 2'd0,
        down  = 2'd1,
        left  = 2'd2,
        right = 2'd3
    } heading_t;

    typedef enum logic [2:0] {
        idle         = 3'd0,
        wait_tick    = 3'd1,
        collision    = 3'd2,
        moving       = 3'd3,
        move_done    = 3'd4,
        eaten_fruit  = 3'd5,
        fruit_update = 3'd6,
        reset_idle   = 3'd7
    } game_state_t;

    localparam int DEFAULT_H_CELLS     = 124;    // Grid width in cells
    localparam int DEFAULT_V_CELLS     = 81;
    localparam int DEFAULT_LENGTH_BITS = 7;      // Max length is 2**bits - 1

    // Start position of head and fruit
    localparam int BEGIN_HEAD_X  = 8;
    localparam int BEGIN_HEAD_Y  = 40;
    localparam int BEGIN_LENGTH  = 6;
    localparam int BEGIN_FRUIT_X = 9;
    localparam int BEGIN_FRUIT_Y = 40;

    localparam int SCORE_WRAP = 99;              // Last score before wrapping to 0

endpackage

//--- rtl/game_fsm.sv
`timescale 1ns/10ps

module game_fsm
    import snake_pkg::*;
(
    input  logic clock_25,
    input  logic reset,
    input  logic right_press,
    input  logic left_press,
    input  logic game_tik,
    input  logic collision,
    input  logic fruit_eaten,
    input  logic placement_bad,
    output logic clear,
    output logic running,
    output logic move,
    output logic grow,
    output logic place,
    output logic start,
    output logic game_over
);

    game_state_t state;
    game_state_t state_next;
    logic        any_press;

    assign any_press = right_press | left_press;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state <= reset_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            reset_idle: begin
                state_next = idle;
            end
            idle: begin
                if (any_press) begin
                    state_next = wait_tick;    // First press starts the game
                end
            end
            wait_tick: begin
                if (game_tik) begin
                    state_next = moving;
                end
            end
            moving: begin
                state_next = move_done;
            end
            move_done: begin
                // Collision wins over eating
                if (collision) begin
                    state_next = snake_pkg::collision;
                end else if (fruit_eaten) begin
                    state_next = eaten_fruit;
                end else begin
                    state_next = wait_tick;
                end
            end
            eaten_fruit: begin
                state_next = fruit_update;
            end
            fruit_update: begin
                if (!placement_bad) begin
                    state_next = wait_tick;    // Keep drawing candidates until one fits
                end
            end
            snake_pkg::collision: begin
                if (any_press) begin
                    state_next = reset_idle;
                end
            end
            default: begin
                state_next = reset_idle;
            end
        endcase
    end

    // Moore outputs
    assign clear     = (state == reset_idle);
    assign running   = (state == idle);
    assign move      = (state == moving);
    assign grow      = (state == eaten_fruit);
    assign place     = (state == fruit_update);
    assign game_over = (state == snake_pkg::collision);
    assign start     = state inside {wait_tick, moving, move_done, eaten_fruit, fruit_update};

    start_excludes_over: assert property (
        @(posedge clock_25) disable iff (!reset) !(start && game_over)
    ) else $error("start and game_over high together");

endmodule

//--- rtl/steer_control.sv
`timescale 1ns/10ps

module steer_control
    import snake_pkg::*;
(
    input  logic     clock_25,
    input  logic     reset,
    input  logic     right_btn,
    input  logic     left_btn,
    input  logic     clear,
    input  logic     running,
    input  logic     move,
    output logic     right_press,
    output logic     left_press,
    output heading_t heading
);

    // Button vectors are {left, right}
    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] press_q;
    logic       turn_cw;         // Pending clockwise turn
    logic       turn_ccw;        // Pending anticlockwise turn
    heading_t   last_heading;    // Direction of the last move

    // Two synchroniser stages, then rising edge detect
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            press_q  <= '0;
        end else begin
            btn_meta <= {left_btn, right_btn};
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            press_q  <= btn_sync & ~btn_prev;
        end
    end

    assign right_press = press_q[0];
    assign left_press  = press_q[1];

    // Move consumes the turn first, so a press on the move cycle is dropped
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (clear || move) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (!running && (right_press || left_press)) begin
            turn_cw  <= right_press & ~left_press;    // Both together cancel
            turn_ccw <= left_press & ~right_press;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            last_heading <= right;
        end else if (clear) begin
            last_heading <= right;
        end else if (move) begin
            last_heading <= heading;
        end
    end

    always_comb begin
        heading = last_heading;
        if (turn_cw) begin
            case (last_heading)
                up:      heading = right;
                right:   heading = down;
                down:    heading = left;
                default: heading = up;
            endcase
        end else if (turn_ccw) begin
            case (last_heading)
                up:      heading = left;
                left:    heading = down;
                down:    heading = right;
                default: heading = up;
            endcase
        end
    end

    no_turn_in_idle: assert property (
        @(posedge clock_25) disable iff (!reset) running |-> !(turn_cw || turn_ccw)
    ) else $error("turn pending while waiting in idle");

endmodule

//--- rtl/snake_body.sv
`timescale 1ns/10ps

module snake_body
    import snake_pkg::*;
#(
    parameter int h_cells     = DEFAULT_H_CELLS,
    parameter int v_cells     = DEFAULT_V_CELLS,
    parameter int length_bits = DEFAULT_LENGTH_BITS
)(
    input  logic                   clock_25,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   move,
    input  logic                   grow,
    input  heading_t               heading,
    input  coord_t                 probe_x,
    input  coord_t                 probe_y,
    output coord_t                 head_x,
    output coord_t                 head_y,
    output logic [length_bits-1:0] length,
    output logic                   collision,
    output logic                   probe_hit
);

    localparam int max_length = 2**length_bits - 1;
    localparam int segments   = max_length - 1;    // Head is kept apart from the store

    coord_t              seg_x [segments];
    coord_t              seg_y [segments];
    coord_t              step_x;
    coord_t              step_y;
    logic                step_ok;
    logic [segments-1:0] live;
    logic [segments-1:0] self_hit;
    logic [segments-1:0] probe_seg_hit;

    // Next head cell, blocked at the grid border
    always_comb begin
        step_x  = head_x;
        step_y  = head_y;
        step_ok = 1'b0;
        case (heading)
            up: begin
                step_ok = (head_y != '0);
                step_y  = head_y - 1'b1;
            end
            down: begin
                step_ok = (head_y < coord_t'(v_cells - 1));
                step_y  = head_y + 1'b1;
            end
            left: begin
                step_ok = (head_x != '0);
                step_x  = head_x - 1'b1;
            end
            default: begin
                step_ok = (head_x < coord_t'(h_cells - 1));
                step_x  = head_x + 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head_x <= coord_t'(BEGIN_HEAD_X);
            head_y <= coord_t'(BEGIN_HEAD_Y);
            length <= length_bits'(BEGIN_LENGTH);
        end else if (clear) begin
            head_x <= coord_t'(BEGIN_HEAD_X);
            head_y <= coord_t'(BEGIN_HEAD_Y);
            length <= length_bits'(BEGIN_LENGTH);
        end else begin
            if (move && step_ok) begin
                head_x <= step_x;
                head_y <= step_y;
            end
            if (grow && length != length_bits'(max_length)) begin
                length <= length + 1'b1;    // Saturates at max length
            end
        end
    end

    // Segment store, shifted behind the head on every step
    always_ff @(posedge clock_25) begin
        if (clear) begin
            for (int i = 0; i < segments; i++) begin
                if (i < BEGIN_LENGTH - 1) begin
                    seg_x[i] <= coord_t'(BEGIN_HEAD_X - 1 - i);
                    seg_y[i] <= coord_t'(BEGIN_HEAD_Y);
                end else begin
                    seg_x[i] <= UNUSED_COORD;
                    seg_y[i] <= UNUSED_COORD;
                end
            end
        end else if (move && step_ok) begin
            seg_x[0] <= head_x;
            seg_y[0] <= head_y;
            for (int i = 1; i < segments; i++) begin
                if (live[i]) begin
                    seg_x[i] <= seg_x[i-1];
                    seg_y[i] <= seg_y[i-1];
                end
            end
        end
    end

    // Parallel compare against every live segment
    always_comb begin
        for (int i = 0; i < segments; i++) begin
            live[i]          = (i < int'(length) - 1);
            self_hit[i]      = live[i] && seg_x[i] == head_x && seg_y[i] == head_y;
            probe_seg_hit[i] = live[i] && seg_x[i] == probe_x && seg_y[i] == probe_y;
        end
    end

    // A blocked step means the head sits on the border facing out
    assign collision = !step_ok || (|self_hit);
    assign probe_hit = (probe_x == head_x && probe_y == head_y) || (|probe_seg_hit);

endmodule

//--- rtl/fruit_placer.sv
`timescale 1ns/10ps

module fruit_placer
    import snake_pkg::*;
#(
    parameter int h_cells = DEFAULT_H_CELLS,
    parameter int v_cells = DEFAULT_V_CELLS
)(
    input  logic                  clock_25,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  grow,
    input  logic                  place,
    input  logic                  probe_hit,
    input  coord_t                head_x,
    input  coord_t                head_y,
    output coord_t                fruit_x,
    output coord_t                fruit_y,
    output logic [SCORE_BITS-1:0] score,
    output logic                  fruit_eaten,
    output logic                  placement_bad
);

    // Index 0 drives x, index 1 drives y
    localparam logic [1:0][COORD_BITS-1:0] lfsr_seed = {7'b0110000, 7'b0011100};

    logic [1:0][COORD_BITS-1:0] lfsr;
    logic                       out_of_field;

    // x^7 + x^6 + 1, both generators free running
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr <= lfsr_seed;
        end else if (clear) begin
            lfsr <= lfsr_seed;
        end else begin
            for (int k = 0; k < 2; k++) begin
                lfsr[k] <= {lfsr[k][COORD_BITS-2:0], lfsr[k][6] ^ lfsr[k][5]};
            end
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit_x <= coord_t'(BEGIN_FRUIT_X);
            fruit_y <= coord_t'(BEGIN_FRUIT_Y);
            score   <= '0;
        end else if (clear) begin
            fruit_x <= coord_t'(BEGIN_FRUIT_X);
            fruit_y <= coord_t'(BEGIN_FRUIT_Y);
            score   <= '0;
        end else if (grow) begin
            fruit_x <= lfsr[0];    // First candidate, checked during placement
            fruit_y <= lfsr[1];
            if (score == SCORE_BITS'(SCORE_WRAP)) begin
                score <= '0;
            end else begin
                score <= score + 1'b1;
            end
        end else if (place && placement_bad) begin
            fruit_x <= lfsr[0];
            fruit_y <= lfsr[1];
        end
    end

    // Fruit must stay inside the inner playfield
    assign out_of_field = (fruit_x <= coord_t'(1)) || (fruit_x >= coord_t'(h_cells - 1)) ||
                          (fruit_y <= coord_t'(1)) || (fruit_y >= coord_t'(v_cells - 1));

    assign placement_bad = probe_hit || out_of_field;
    assign fruit_eaten   = (fruit_x == head_x) && (fruit_y == head_y);

    // Only the head can reach a placed fruit
    placed_fruit_valid: assert property (
        @(posedge clock_25) disable iff (!reset)
        (!place && !clear && !fruit_eaten) |-> !placement_bad
    ) else $error("fruit left on snake or outside playfield");

endmodule

//--- rtl/snake_game_top.sv
`timescale 1ns/10ps

module snake_game_top
    import snake_pkg::*;
#(
    parameter int h_cells     = DEFAULT_H_CELLS,
    parameter int v_cells     = DEFAULT_V_CELLS,
    parameter int length_bits = DEFAULT_LENGTH_BITS
)(
    input  logic                   clock_25,
    input  logic                   reset,
    input  logic                   right_btn,
    input  logic                   left_btn,
    input  logic                   game_tik,
    output logic                   start,
    output logic                   game_over,
    output coord_t                 head_x,
    output coord_t                 head_y,
    output coord_t                 fruit_x,
    output coord_t                 fruit_y,
    output heading_t               heading,
    output logic [SCORE_BITS-1:0]  score,
    output logic [length_bits-1:0] length
);

    // Control strobes from the FSM
    logic clear;
    logic running;
    logic move;
    logic grow;
    logic place;

    logic right_press;
    logic left_press;
    logic collision;
    logic probe_hit;
    logic fruit_eaten;
    logic placement_bad;

    game_fsm fsm0 (
        .clock_25      (clock_25),
        .reset         (reset),
        .right_press   (right_press),
        .left_press    (left_press),
        .game_tik      (game_tik),
        .collision     (collision),
        .fruit_eaten   (fruit_eaten),
        .placement_bad (placement_bad),
        .clear         (clear),
        .running       (running),
        .move          (move),
        .grow          (grow),
        .place         (place),
        .start         (start),
        .game_over     (game_over)
    );

    steer_control steer0 (
        .clock_25    (clock_25),
        .reset       (reset),
        .right_btn   (right_btn),
        .left_btn    (left_btn),
        .clear       (clear),
        .running     (running),
        .move        (move),
        .right_press (right_press),
        .left_press  (left_press),
        .heading     (heading)
    );

    snake_body #(
        .h_cells     (h_cells),
        .v_cells     (v_cells),
        .length_bits (length_bits)
    ) body0 (
        .clock_25  (clock_25),
        .reset     (reset),
        .clear     (clear),
        .move      (move),
        .grow      (grow),
        .heading   (heading),
        .probe_x   (fruit_x),     // Fruit position is the occupancy probe
        .probe_y   (fruit_y),
        .head_x    (head_x),
        .head_y    (head_y),
        .length    (length),
        .collision (collision),
        .probe_hit (probe_hit)
    );

    fruit_placer #(
        .h_cells (h_cells),
        .v_cells (v_cells)
    ) fruit0 (
        .clock_25      (clock_25),
        .reset         (reset),
        .clear         (clear),
        .grow          (grow),
        .place         (place),
        .probe_hit     (probe_hit),
        .head_x        (head_x),
        .head_y        (head_y),
        .fruit_x       (fruit_x),
        .fruit_y       (fruit_y),
        .score         (score),
        .fruit_eaten   (fruit_eaten),
        .placement_bad (placement_bad)
    );

endmodule

//--- dv/snake_game_vectors.svh
`ifndef SNAKE_GAME_VECTORS_SVH
`define SNAKE_GAME_VECTORS_SVH

task automatic fill_steps();
    // Columns: action, repeats, head x, head y, heading, start, game_over, score, length
    // no_check leaves score or length to the fruit rule of the model
    add_step(act_none,   1,  8, 40, right, 0, 0, 0, 6);    // State after reset
    add_step(act_right,  1,  8, 40, right, 1, 0, 0, 6);    // Start without a turn
    add_step(act_tick,   1,  9, 40, right, 1, 0, 1, 7);    // Eats the start fruit

    // Single turns
    add_step(act_right,  1,  9, 40, down,  1, 0, no_check, no_check);
    add_step(act_tick,   1,  9, 41, down,  1, 0, no_check, no_check);
    add_step(act_left,   1,  9, 41, right, 1, 0, no_check, no_check);
    add_step(act_tick,   1, 10, 41, right, 1, 0, no_check, no_check);

    // Two presses, one turn
    add_step(act_right,  1, 10, 41, down,  1, 0, no_check, no_check);
    add_step(act_right,  1, 10, 41, down,  1, 0, no_check, no_check);
    add_step(act_tick,   1, 10, 42, down,  1, 0, no_check, no_check);

    add_step(act_both,   1, 10, 42, down,  1, 0, no_check, no_check);    // Cancels out
    add_step(act_tick,   1, 10, 43, down,  1, 0, no_check, no_check);

    // Three right turns run into the body
    add_step(act_right,  1, 10, 43, left,  1, 0, no_check, no_check);
    add_step(act_tick,   1,  9, 43, left,  1, 0, no_check, no_check);
    add_step(act_right,  1,  9, 43, up,    1, 0, no_check, no_check);
    add_step(act_tick,   1,  9, 42, up,    1, 0, no_check, no_check);
    add_step(act_right,  1,  9, 42, right, 1, 0, no_check, no_check);
    add_step(act_tick,   1, 10, 42, right, 0, 1, no_check, no_check);
    add_step(act_tick,   1, 10, 42, right, 0, 1, no_check, no_check);    // Ignored

    // Restart, then run up into the top wall
    add_step(act_right,  1,  8, 40, right, 0, 0, 0, 6);
    add_step(act_left,   1,  8, 40, right, 1, 0, 0, 6);
    add_step(act_left,   1,  8, 40, up,    1, 0, 0, 6);
    add_step(act_tick,  39,  8,  1, up,    1, 0, 0, 6);
    add_step(act_tick,   1,  8,  0, up,    0, 1, 0, 6);
    add_step(act_tick,   1,  8,  0, up,    0, 1, 0, 6);
endtask

`endif

//--- dv/snake_game_tb.sv
`timescale 1ns/10ps

module snake_game_tb
    import snake_pkg::*;
();

    localparam int step_wait  = 256;    // Cycles between stimulus and check
    localparam int no_check   = 255;
    localparam int max_length = 2**DEFAULT_LENGTH_BITS - 1;

    localparam int act_none  = 0;
    localparam int act_right = 1;
    localparam int act_left  = 2;
    localparam int act_both  = 3;
    localparam int act_tick  = 4;

    localparam int mode_idle = 0;
    localparam int mode_run  = 1;
    localparam int mode_over = 2;

    typedef struct packed {
        logic [2:0] kind;
        logic [7:0] reps;
        coord_t     x;
        coord_t     y;
        heading_t   head_dir;
        logic       start;
        logic       over;
        logic [7:0] score;
        logic [7:0] length;
    } step_t;

    logic                           clock_25 = 1'b0;
    logic                           reset;
    logic                           right_btn;
    logic                           left_btn;
    logic                           game_tik;
    logic                           start;
    logic                           game_over;
    coord_t                         head_x;
    coord_t                         head_y;
    coord_t                         fruit_x;
    coord_t                         fruit_y;
    heading_t                       heading;
    logic [SCORE_BITS-1:0]          score;
    logic [DEFAULT_LENGTH_BITS-1:0] length;

    step_t steps [$];
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    failures    = 0;

    // Reference model of the game rules
    int       m_mode;
    heading_t m_last;             // Heading of the last move
    int       m_turn;             // 0 none, 1 clockwise, 2 anticlockwise
    coord_t   m_x;
    coord_t   m_y;
    int       m_score;
    int       m_length;
    coord_t   m_fruit_x;
    coord_t   m_fruit_y;
    logic     m_ate;
    coord_t   body_x [$];         // Live segments, nearest to the head first
    coord_t   body_y [$];

    snake_game_top dut0 (
        .clock_25  (clock_25),
        .reset     (reset),
        .right_btn (right_btn),
        .left_btn  (left_btn),
        .game_tik  (game_tik),
        .start     (start),
        .game_over (game_over),
        .head_x    (head_x),
        .head_y    (head_y),
        .fruit_x   (fruit_x),
        .fruit_y   (fruit_y),
        .heading   (heading),
        .score     (score),
        .length    (length)
    );

    always #4 clock_25 = ~clock_25;

    always @(posedge clock_25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
        end
    end

    task automatic report_failure(input string msg);
        failures++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            report_failure(what);
        end
    endtask

    task automatic add_step(input int kind, input int reps, input int x, input int y,
                            input heading_t head_dir, input int start_exp, input int over_exp,
                            input int score_exp, input int length_exp);
        step_t s;
        s.kind     = 3'(kind);
        s.reps     = 8'(reps);
        s.x        = coord_t'(x);
        s.y        = coord_t'(y);
        s.head_dir = head_dir;
        s.start    = start_exp[0];
        s.over     = over_exp[0];
        s.score    = 8'(score_exp);
        s.length   = 8'(length_exp);
        steps.push_back(s);
    endtask

    `include "snake_game_vectors.svh"

    function automatic heading_t turn_heading(input heading_t h, input int turn);
        heading_t r;
        r = h;
        if (turn == 1) begin
            case (h)
                up:      r = right;
                right:   r = down;
                down:    r = left;
                default: r = up;
            endcase
        end else if (turn == 2) begin
            case (h)
                up:      r = left;
                left:    r = down;
                down:    r = right;
                default: r = up;
            endcase
        end
        return r;
    endfunction

    // Head on a border cell facing out of the grid
    function automatic logic outward_at_border(input coord_t x, input coord_t y,
                                               input heading_t h);
        case (h)
            up:      return y == 0;
            down:    return y == coord_t'(DEFAULT_V_CELLS - 1);
            left:    return x == 0;
            default: return x == coord_t'(DEFAULT_H_CELLS - 1);
        endcase
    endfunction

    task automatic model_home();
        m_mode    = mode_idle;
        m_last    = right;
        m_turn    = 0;
        m_x       = coord_t'(BEGIN_HEAD_X);
        m_y       = coord_t'(BEGIN_HEAD_Y);
        m_score   = 0;
        m_length  = BEGIN_LENGTH;
        m_fruit_x = coord_t'(BEGIN_FRUIT_X);
        m_fruit_y = coord_t'(BEGIN_FRUIT_Y);
        m_ate     = 1'b0;
        body_x.delete();
        body_y.delete();
        for (int i = 1; i < BEGIN_LENGTH; i++) begin
            body_x.push_back(coord_t'(BEGIN_HEAD_X - i));
            body_y.push_back(coord_t'(BEGIN_HEAD_Y));
        end
    endtask

    task automatic model_press(input int act);
        case (m_mode)
            mode_idle: m_mode = mode_run;    // First press starts the game
            mode_over: model_home();
            default:   m_turn = (act == act_right) ? 1 : (act == act_left) ? 2 : 0;
        endcase
    endtask

    task automatic model_tick();
        heading_t hd;
        logic     hit;
        m_ate = 1'b0;
        if (m_mode == mode_run) begin
            hd     = turn_heading(m_last, m_turn);
            m_turn = 0;
            m_last = hd;
            if (!outward_at_border(m_x, m_y, hd)) begin
                body_x.push_front(m_x);
                body_y.push_front(m_y);
                while (body_x.size() > m_length - 1) begin
                    void'(body_x.pop_back());
                    void'(body_y.pop_back());
                end
                case (hd)
                    up:      m_y = m_y - 1'b1;
                    down:    m_y = m_y + 1'b1;
                    left:    m_x = m_x - 1'b1;
                    default: m_x = m_x + 1'b1;
                endcase
            end
            hit = outward_at_border(m_x, m_y, hd);
            foreach (body_x[i]) begin
                if (body_x[i] == m_x && body_y[i] == m_y) begin
                    hit = 1'b1;
                end
            end
            if (hit) begin
                m_mode = mode_over;
            end else if (m_x == m_fruit_x && m_y == m_fruit_y) begin
                m_ate    = 1'b1;
                m_score  = (m_score == SCORE_WRAP) ? 0 : m_score + 1;
                m_length = (m_length == max_length) ? max_length : m_length + 1;
            end
        end
    endtask

    task automatic check_model();
        check_value("head_x", m_x, head_x);
        check_value("head_y", m_y, head_y);
        check_value("heading", turn_heading(m_last, m_turn), heading);
        check_value("start", m_mode == mode_run, start);
        check_value("game_over", m_mode == mode_over, game_over);
        check_value("score", m_score, score);
        check_value("length", m_length, length);
        if (m_ate) begin
            check_true(fruit_x >= 2 && fruit_x <= DEFAULT_H_CELLS - 2 &&
                       fruit_y >= 2 && fruit_y <= DEFAULT_V_CELLS - 2,
                       "New fruit was placed outside the inner playfield");
            check_true(!(fruit_x == m_x && fruit_y == m_y), "New fruit was placed on the head");
            foreach (body_x[i]) begin
                check_true(!(fruit_x == body_x[i] && fruit_y == body_y[i]),
                           "New fruit was placed on a body segment");
            end
            m_fruit_x = fruit_x;    // Random position accepted once it is valid
            m_fruit_y = fruit_y;
            m_ate     = 1'b0;       // Later checks expect this fruit to stay put
        end else begin
            check_value("fruit_x", m_fruit_x, fruit_x);
            check_value("fruit_y", m_fruit_y, fruit_y);
        end
    endtask

    task automatic check_table(input step_t s);
        check_value("head_x", s.x, head_x);
        check_value("head_y", s.y, head_y);
        check_value("heading", s.head_dir, heading);
        check_value("start", s.start, start);
        check_value("game_over", s.over, game_over);
        if (s.score != no_check) begin
            check_value("score", s.score, score);
        end
        if (s.length != no_check) begin
            check_value("length", s.length, length);
        end
    endtask

    task automatic apply_step(input step_t s);
        int r;
        for (r = 0; r < s.reps; r++) begin
            @(negedge clock_25);
            case (s.kind)
                act_right: right_btn = 1'b1;
                act_left:  left_btn = 1'b1;
                act_both: begin
                    right_btn = 1'b1;
                    left_btn  = 1'b1;
                end
                act_tick:  game_tik = 1'b1;
                default:   ;
            endcase
            if (s.kind == act_tick) begin
                @(negedge clock_25);
                model_tick();
            end else if (s.kind != act_none) begin
                repeat (2) @(negedge clock_25);    // Buttons held two cycles
                model_press(s.kind);
            end
            right_btn = 1'b0;
            left_btn  = 1'b0;
            game_tik  = 1'b0;
            repeat (step_wait) @(negedge clock_25);
            check_model();
        end
        check_table(s);
    endtask

    initial begin
        int total_reps;
        reset     = 1'b0;
        right_btn = 1'b0;
        left_btn  = 1'b0;
        game_tik  = 1'b0;
        fill_steps();
        total_reps = 0;
        foreach (steps[i]) begin
            total_reps += steps[i].reps;
        end
        cycle_limit = total_reps * 300 + 1000;
        model_home();
        repeat (8) @(negedge clock_25);
        reset = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        if (failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- snake_game_top.f
+incdir+dv
rtl/snake_pkg.sv
rtl/game_fsm.sv
rtl/steer_control.sv
rtl/snake_body.sv
rtl/fruit_placer.sv
rtl/snake_game_top.sv
dv/snake_game_tb.sv

//--- Bender.yml
package:
  name: snake_game

sources:
  - files:
      - rtl/snake_pkg.sv
      - rtl/game_fsm.sv
      - rtl/steer_control.sv
      - rtl/snake_body.sv
      - rtl/fruit_placer.sv
      - rtl/snake_game_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/snake_game_tb.sv
